// ==== verilog/clk_div_pkg.sv ====
package clk_div_pkg;

  // default width of the division value and of the period counter
  // the period of the divided clock is the division value plus one cycles
  localparam int DIV_WIDTH = 8;

  // default width of the done counter
  // the done flag rises once this counter saturates at all ones
  // so with three bits it takes seven completed periods
  localparam int DONE_WIDTH = 3;

  // opcodes carried on the command port alongside the data word
  // only CMD_SET_DIV looks at the data word
  typedef enum logic [1:0] {
    // no operation, the strobe is accepted and ignored
    CMD_NOP     = 2'd0,
    // load the division value from the data word, zero is rejected
    CMD_SET_DIV = 2'd1,
    // start the divider and restart the period from count zero
    CMD_ENABLE  = 2'd2,
    // freeze the divider where it stands
    CMD_DISABLE = 2'd3
  } cmd_op_e;

  // the encoding is fixed at two bits so the command port width
  // never changes when opcodes are renamed
  // any new opcode has to fit in the unused space, and there is none left

endpackage

// ==== verilog/clk_div_cfg_if.sv ====
`timescale 1ns/1ps

// configuration path from the register block to the divider core
// everything here is driven from flops on the register side
interface clk_div_cfg_if #(
  parameter int DIV_WIDTH = clk_div_pkg::DIV_WIDTH
);

  // division value currently in force
  // the core counts from zero up to this value and wraps
  logic [DIV_WIDTH-1:0] div_value;

  // divider runs while this is high and freezes while it is low
  logic enable;

  // one cycle pulse after a new division value or an enable
  // the core clears its counter, its clock and its done counter on it
  logic restart;

  // returned by the core once enough periods have completed
  logic done;

  // the register block owns the configuration and only watches done
  modport regs_mp (
    output div_value,
    output enable,
    output restart,
    input  done
  );

  // the core consumes the configuration and reports done back
  modport div_mp (
    input  div_value,
    input  enable,
    input  restart,
    output done
  );

endinterface

// ==== verilog/clk_div_regs.sv ====
`timescale 1ns/1ps

module clk_div_regs #(
  parameter int DIV_WIDTH = clk_div_pkg::DIV_WIDTH
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  cmd_valid_i,
  input  clk_div_pkg::cmd_op_e  cmd_op_i,
  input  logic [DIV_WIDTH-1:0]  cmd_data_i,
  clk_div_cfg_if.regs_mp        cfg,
  output logic                  cfg_err_o
);

  import clk_div_pkg::*;

  // configuration registers, the core only ever sees these flops
  logic [DIV_WIDTH-1:0] div_q;
  logic                 en_q;
  logic                 restart_q;
  logic                 err_q;

  // a set command with a zero data word would ask for a bypassed clock
  // which this divider does not support, so it is flagged instead
  logic                 set_zero;

  assign set_zero = (cmd_data_i == '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // a division value of one gives the fastest legal divided clock
      div_q     <= DIV_WIDTH'(1);
      en_q      <= 1'b0;
      restart_q <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      // restart is a pulse and drops unless a command raises it again
      restart_q <= 1'b0;
      if (cmd_valid_i) begin
        case (cmd_op_i)
          CMD_SET_DIV: begin
            if (set_zero) begin
              // sticky until reset, the old value stays in force
              err_q <= 1'b1;
            end else begin
              div_q     <= cmd_data_i;
              restart_q <= 1'b1;
            end
          end
          CMD_ENABLE: begin
            en_q      <= 1'b1;
            restart_q <= 1'b1;
          end
          CMD_DISABLE: begin
            // no restart here so the core freezes with its state intact
            en_q <= 1'b0;
          end
          CMD_NOP: begin
            // accepted and ignored
          end
          default: begin
          end
        endcase
      end
    end
  end

  assign cfg.div_value = div_q;
  assign cfg.enable    = en_q;
  assign cfg.restart   = restart_q;
  assign cfg_err_o     = err_q;

  // restart only repeats when a fresh command arrives in the pulse cycle
  a_restart_pulse : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (cfg.restart && !cmd_valid_i) |=> !cfg.restart
  );

  // the core must have cleared its done counter on the restart edge
  a_restart_clears_done : assert property (
    @(posedge clk_i) disable iff (reset_i)
    cfg.restart |=> !cfg.done
  );

endmodule

// ==== verilog/clk_int_div.sv ====
`timescale 1ns/1ps

module clk_int_div #(
  parameter int DIV_WIDTH  = clk_div_pkg::DIV_WIDTH,
  parameter int DONE_WIDTH = clk_div_pkg::DONE_WIDTH
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  clk_div_cfg_if.div_mp        cfg,
  output logic [DIV_WIDTH-1:0] clk_cnt_o,
  output logic                 clk_trg_o,
  output logic                 clk_o,
  output logic                 div_done_o
);

  // period counter, runs from zero up to the division value
  logic [DIV_WIDTH-1:0]  cnt_q;

  // toggle register behind the divided clock output
  logic                  clk_q;

  // counts completed periods and saturates at all ones
  logic [DONE_WIDTH-1:0] done_q;

  // count at which the first toggle of a period happens
  // for a value of 3 this is count 1, for a value of 1 or 2 it is count 0
  logic [DIV_WIDTH-1:0]  mid_cnt;

  // last count of the current period
  logic                  at_end;

  // first toggle point of the current period
  logic                  at_mid;

  // high while the done counter sits at its ceiling
  logic                  done_sat;

  assign mid_cnt  = (cfg.div_value - 1'b1) >> 1;
  assign at_end   = (cnt_q == cfg.div_value);
  assign at_mid   = (cnt_q == mid_cnt);
  assign done_sat = &done_q;

  // the trigger marks the last cycle of every running period
  assign clk_trg_o = cfg.enable && at_end;

  // counter steps while enabled and holds its value otherwise
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (cfg.restart) begin
      cnt_q <= '0;
    end else if (cfg.enable) begin
      if (at_end) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // divided clock toggles once mid period and once at the wrap
  // the high phase therefore lasts div_value minus mid_cnt cycles
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      clk_q <= 1'b0;
    end else if (cfg.restart) begin
      // every new configuration starts from a low phase
      clk_q <= 1'b0;
    end else if (cfg.enable && (at_mid || at_end)) begin
      clk_q <= ~clk_q;
    end
  end

  // one step per trigger until the counter hits its ceiling
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_q <= '0;
    end else if (cfg.restart) begin
      done_q <= '0;
    end else if (clk_trg_o && !done_sat) begin
      done_q <= done_q + 1'b1;
    end
  end

  assign clk_cnt_o  = cnt_q;
  assign clk_o      = clk_q;
  assign div_done_o = done_sat;

  // the register block watches done as well
  assign cfg.done   = done_sat;

  // the division value only moves together with a restart pulse
  // so outside that pulse a running count stays within range
  a_cnt_in_range : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (cfg.enable && !cfg.restart) |-> (cnt_q <= cfg.div_value)
  );

  // a trigger always closes the period, either by wrap or by restart
  a_trg_wraps : assert property (
    @(posedge clk_i) disable iff (reset_i)
    clk_trg_o |=> (cnt_q == '0)
  );

endmodule

// ==== verilog/clk_div_top.sv ====
`timescale 1ns/1ps

module clk_div_top #(
  parameter int DIV_WIDTH  = clk_div_pkg::DIV_WIDTH,
  parameter int DONE_WIDTH = clk_div_pkg::DONE_WIDTH
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 cmd_valid_i,
  input  clk_div_pkg::cmd_op_e cmd_op_i,
  input  logic [DIV_WIDTH-1:0] cmd_data_i,
  output logic                 clk_o,
  output logic                 clk_trg_o,
  output logic                 div_done_o,
  output logic                 cfg_err_o,
  output logic [DIV_WIDTH-1:0] clk_cnt_o
);

  // configuration bundle between the register block and the core
  clk_div_cfg_if #(
    .DIV_WIDTH (DIV_WIDTH)
  ) i_cfg ();

  // command decode and configuration flops
  // any command takes effect on the core one cycle after its strobe
  clk_div_regs #(
    .DIV_WIDTH (DIV_WIDTH)
  ) i_regs (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_data_i  (cmd_data_i),
    .cfg         (i_cfg.regs_mp),
    .cfg_err_o   (cfg_err_o)
  );

  // divider core
  // after a set or enable strobe the first trigger is div_value plus two cycles out
  clk_int_div #(
    .DIV_WIDTH  (DIV_WIDTH),
    .DONE_WIDTH (DONE_WIDTH)
  ) i_div (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cfg        (i_cfg.div_mp),
    .clk_cnt_o  (clk_cnt_o),
    .clk_trg_o  (clk_trg_o),
    .clk_o      (clk_o),
    .div_done_o (div_done_o)
  );

endmodule

// ==== bench/clk_div_checker.sv ====
`timescale 1ns/1ps

module clk_div_checker #(
  parameter int DIV_WIDTH  = clk_div_pkg::DIV_WIDTH,
  parameter int DONE_WIDTH = clk_div_pkg::DONE_WIDTH
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 cmd_valid_i,
  input  clk_div_pkg::cmd_op_e cmd_op_i,
  input  logic [DIV_WIDTH-1:0] cmd_data_i,
  input  logic                 clk_o,
  input  logic                 clk_trg_o,
  input  logic                 div_done_o,
  input  logic                 cfg_err_o,
  input  logic [DIV_WIDTH-1:0] clk_cnt_o,
  input  logic [8*16-1:0]      test_name_i,
  input  logic                 row_done_i,
  input  logic                 gap_chk_i,
  input  logic [DIV_WIDTH-1:0] exp_div_i,
  input  logic                 exp_err_i,
  output int                   err_cnt_o
);

  import clk_div_pkg::*;

  // done rises once this many triggers have completed since a restart
  localparam int DONE_MAX = (1 << DONE_WIDTH) - 1;

  // configuration as the core sees it, one cycle behind the command port
  logic [DIV_WIDTH-1:0] m_div;
  logic                 m_en;
  logic                 m_rst;
  logic                 m_err;

  // expected position inside the period and triggers since the last restart
  int                   phase;
  int                   ntrg;
  int                   mid;

  // expected level of the divided clock in the cycle just ended
  logic                 m_clk;

  // spacing between the last two triggers seen on the port
  int                   since_trg;
  int                   last_gap;
  logic                 seen_trg;

  int                   errors = 0;

  assign err_cnt_o = errors;

  task automatic compare(input string what, input int exp, input int act);
    if (exp != act) begin
      errors++;
      $display("[FAIL] %0s: %0s expected %0d actual %0d at %0t",
               test_name_i, what, exp, act, $time);
    end
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      m_div     = DIV_WIDTH'(1);
      m_en      = 1'b0;
      m_rst     = 1'b0;
      m_err     = 1'b0;
      phase     = 0;
      ntrg      = 0;
      m_clk     = 1'b0;
      since_trg = 0;
      last_gap  = 0;
      seen_trg  = 1'b0;
    end else begin
      // values sampled here were stable through the whole cycle that just ended
      mid = (int'(m_div) - 1) / 2;
      compare("clk_trg_o", int'(m_en && (phase == int'(m_div))), int'(clk_trg_o));
      compare("clk_cnt_o", phase, int'(clk_cnt_o));
      compare("clk_o", int'(m_clk), int'(clk_o));
      compare("div_done_o", int'(ntrg >= DONE_MAX), int'(div_done_o));
      compare("cfg_err_o", int'(m_err), int'(cfg_err_o));

      since_trg++;
      if (clk_trg_o) begin
        if (seen_trg) begin
          last_gap = since_trg;
        end
        seen_trg  = 1'b1;
        since_trg = 0;
      end

      // end of a table row, so the measured spacing must fit the row's value
      if (row_done_i) begin
        if (gap_chk_i) begin
          compare("trigger gap", int'(exp_div_i) + 1, last_gap);
        end
        compare("error flag", int'(exp_err_i), int'(cfg_err_o));
      end

      // core side, a restart wins over a running count
      if (m_rst) begin
        phase    = 0;
        ntrg     = 0;
        m_clk    = 1'b0;
        seen_trg = 1'b0;
      end else if (m_en) begin
        // the divided clock flips when leaving the midpoint and when leaving the last count
        // so it is high from the cycle after the midpoint to the period end
        if ((phase == mid) || (phase == int'(m_div))) begin
          m_clk = ~m_clk;
        end
        if (phase == int'(m_div)) begin
          phase = 0;
          if (ntrg < DONE_MAX) begin
            ntrg++;
          end
        end else begin
          phase++;
        end
      end

      // register side, whatever is accepted now reaches the core next cycle
      m_rst = 1'b0;
      if (cmd_valid_i) begin
        case (cmd_op_i)
          CMD_SET_DIV: begin
            if (cmd_data_i == '0) begin
              m_err = 1'b1;
            end else begin
              m_div = cmd_data_i;
              m_rst = 1'b1;
            end
          end
          CMD_ENABLE: begin
            m_en  = 1'b1;
            m_rst = 1'b1;
          end
          CMD_DISABLE: begin
            m_en = 1'b0;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

// ==== bench/tb_clk_div.sv ====
`timescale 1ns/1ps

module tb_clk_div;

  import clk_div_pkg::*;

  localparam int NUM_ROWS = 10;
  localparam int NAME_W   = 8 * 16;
  // cycles spent on a row that waits for no trigger
  localparam int IDLE_CYC = 20;
  localparam int MARGIN   = 200;

  // one row of the stimulus table
  typedef struct {
    logic [NAME_W-1:0]    name;
    cmd_op_e              op;
    logic [DIV_WIDTH-1:0] data;
    int                   per;
    logic [DIV_WIDTH-1:0] div;
    logic                 err;
  } row_t;

  row_t                 rows [NUM_ROWS];
  logic                 clk_i;
  logic                 reset_i;
  logic                 cmd_valid_i;
  cmd_op_e              cmd_op_i;
  logic [DIV_WIDTH-1:0] cmd_data_i;
  logic                 clk_o;
  logic                 clk_trg_o;
  logic                 div_done_o;
  logic                 cfg_err_o;
  logic [DIV_WIDTH-1:0] clk_cnt_o;
  logic [NAME_W-1:0]    cur_name;
  logic                 row_done;
  logic                 gap_chk;
  logic [DIV_WIDTH-1:0] exp_div;
  logic                 exp_err;
  int                   err_cnt;
  int                   cycles;
  int                   limit;

  always #10 clk_i = ~clk_i;

  clk_div_top i_dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_data_i  (cmd_data_i),
    .clk_o       (clk_o),
    .clk_trg_o   (clk_trg_o),
    .div_done_o  (div_done_o),
    .cfg_err_o   (cfg_err_o),
    .clk_cnt_o   (clk_cnt_o)
  );

  clk_div_checker i_chk (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_data_i  (cmd_data_i),
    .clk_o       (clk_o),
    .clk_trg_o   (clk_trg_o),
    .div_done_o  (div_done_o),
    .cfg_err_o   (cfg_err_o),
    .clk_cnt_o   (clk_cnt_o),
    .test_name_i (cur_name),
    .row_done_i  (row_done),
    .gap_chk_i   (gap_chk),
    .exp_div_i   (exp_div),
    .exp_err_i   (exp_err),
    .err_cnt_o   (err_cnt)
  );

  // triggers are looked at on the falling edge, each one counted once
  task automatic wait_triggers(input int n);
    repeat (n) begin
      @(negedge clk_i);
      while (!clk_trg_o) begin
        @(negedge clk_i);
      end
    end
  endtask

  initial begin
    logic [DIV_WIDTH-1:0] r_a;
    logic [DIV_WIDTH-1:0] r_b;
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_op_i    = CMD_NOP;
    cmd_data_i  = '0;
    row_done    = 1'b0;
    gap_chk     = 1'b0;
    exp_div     = '0;
    exp_err     = 1'b0;
    cur_name    = NAME_W'("reset");
    void'($urandom(32'h51ff));
    r_a = DIV_WIDTH'($urandom_range(40, 8));
    r_b = DIV_WIDTH'($urandom_range(40, 8));
    // name, opcode, data, trigger periods, division value in force, error flag
    rows[0] = '{NAME_W'("enable"), CMD_ENABLE, DIV_WIDTH'(0), 8, DIV_WIDTH'(1), 1'b0};
    rows[1] = '{NAME_W'("div_2"), CMD_SET_DIV, DIV_WIDTH'(2), 8, DIV_WIDTH'(2), 1'b0};
    rows[2] = '{NAME_W'("div_3"), CMD_SET_DIV, DIV_WIDTH'(3), 3, DIV_WIDTH'(3), 1'b0};
    rows[3] = '{NAME_W'("disable"), CMD_DISABLE, DIV_WIDTH'(0), 0, DIV_WIDTH'(3), 1'b0};
    rows[4] = '{NAME_W'("reenable"), CMD_ENABLE, DIV_WIDTH'(0), 3, DIV_WIDTH'(3), 1'b0};
    rows[5] = '{NAME_W'("div_7"), CMD_SET_DIV, DIV_WIDTH'(7), 8, DIV_WIDTH'(7), 1'b0};
    // a zero value is refused and the old spacing carries on
    rows[6] = '{NAME_W'("zero_div"), CMD_SET_DIV, DIV_WIDTH'(0), 3, DIV_WIDTH'(7), 1'b1};
    rows[7] = '{NAME_W'("nop"), CMD_NOP, DIV_WIDTH'(0), 2, DIV_WIDTH'(7), 1'b1};
    rows[8] = '{NAME_W'("rand_a"), CMD_SET_DIV, r_a, 3, r_a, 1'b1};
    rows[9] = '{NAME_W'("rand_b"), CMD_SET_DIV, r_b, 8, r_b, 1'b1};
    // worst case per row is the first period plus the following ones
    limit = MARGIN;
    foreach (rows[i]) begin
      limit += (int'(rows[i].div) + 2) * rows[i].per;
      if (rows[i].per == 0) begin
        limit += IDLE_CYC;
      end
    end

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    foreach (rows[i]) begin
      cur_name    = rows[i].name;
      exp_div     = rows[i].div;
      exp_err     = rows[i].err;
      gap_chk     = (rows[i].per > 1);
      cmd_valid_i = 1'b1;
      cmd_op_i    = rows[i].op;
      cmd_data_i  = rows[i].data;
      @(negedge clk_i);
      cmd_valid_i = 1'b0;
      if (rows[i].per == 0) begin
        repeat (IDLE_CYC) @(negedge clk_i);
      end else begin
        wait_triggers(rows[i].per);
      end
      // the checker samples this on the edge that closes the last trigger
      row_done = 1'b1;
      @(negedge clk_i);
      row_done = 1'b0;
    end

    @(negedge clk_i);
    $display("run complete with %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // cycle budget counted from the end of reset
  initial begin
    cycles = 0;
    @(negedge reset_i);
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles, the expected triggers never all arrived", cycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== tb.f ====
verilog/clk_div_pkg.sv
verilog/clk_div_cfg_if.sv
verilog/clk_div_regs.sv
verilog/clk_int_div.sv
verilog/clk_div_top.sv
bench/clk_div_checker.sv
bench/tb_clk_div.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_clk_div
FILELIST = tb.f
SRCS     = $(shell cat $(FILELIST))
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

# the simulator binary is rebuilt only when a source or the file list changes
obj_dir/V%: $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $* -f $(FILELIST)

# pass or fail is taken from the log, not from the exit code
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
